// ==== sim.f ====
+incdir+rtl
rtl/mvm_pkg.sv
rtl/mvm_issue_if.sv
rtl/mvm_ram.sv
rtl/mvm_fifo.sv
rtl/mvm_ingress.sv
rtl/mvm_sequencer.sv
rtl/mvm_accum.sv
rtl/mvm_lane.sv
rtl/mvm_top.sv
sim/mvm_tb.sv

// ==== Makefile ====
TOP = mvm_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Verification passed$$" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== sim/mvm_tb.sv ====
/* MVM engine testbench */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_tb;

localparam int TIMEOUT = 2000;

logic                    clk;
logic                    rst;
logic                    rx_tvalid;
logic [`MVM_DATA_W-1:0]  rx_tdata;
logic [`MVM_TID_W-1:0]   rx_tid;
logic [`MVM_TUSER_W-1:0] rx_tuser;
logic                    rx_tready;
logic                    tx_tvalid;
logic [`MVM_DATA_W-1:0]  tx_tdata;
logic                    tx_tready;

logic [31:0] seed;
logic [31:0] ready_seed;
logic        hold_tx;     // Forces tx_tready low.
logic        random_tx;   // Drops tx_tready at random.
logic        hold_now;
logic        random_now;

logic [`MVM_DATA_W-1:0] weight_model [`MVM_LANES][`MVM_MEM_DEPTH];
logic [15:0]            inst_model [`MVM_MEM_DEPTH];
logic [`MVM_DATA_W-1:0] accum_model [`MVM_MEM_DEPTH];
bit                     accum_known [`MVM_MEM_DEPTH];
logic [`MVM_DATA_W-1:0] input_q [$];
logic [`MVM_DATA_W-1:0] reduce_q [$];
logic [`MVM_DATA_W-1:0] expect_q [$];
logic [`MVM_DATA_W-1:0] want;

mvm_top UUT (
	.clk(clk), .rst(rst), .rx_tvalid(rx_tvalid), .rx_tdata(rx_tdata), .rx_tid(rx_tid),
	.rx_tuser(rx_tuser), .rx_tready(rx_tready), .tx_tvalid(tx_tvalid),
	.tx_tdata(tx_tdata), .tx_tready(tx_tready)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function logic [31:0] rand32();
	seed = lcg_next(seed);
	return seed;
endfunction

function automatic logic [`MVM_DATA_W-1:0] rand128();
	logic [`MVM_DATA_W-1:0] v;
	for (int i = 0; i < `MVM_DATA_W / 32; i++) begin
		v[i*32 +: 32] = rand32();
	end
	return v;
endfunction

// Unsigned element products summed with 32-bit wrap.
function automatic logic [31:0] lane_dot(input logic [`MVM_DATA_W-1:0] vec,
	input logic [`MVM_DATA_W-1:0] row);
	logic [31:0] sum;
	sum = '0;
	for (int i = 0; i < `MVM_ELEMS; i++) begin
		sum = sum + 32'(vec[i*16 +: 16]) * 32'(row[i*16 +: 16]);
	end
	return sum;
endfunction

task automatic fail_with(input string line);
	$display("%s", line);
	$display("Verification failed");
	$fatal(1, "Run stopped at the first error.");
endtask

task automatic send_beat(input logic [`MVM_TID_W-1:0] id, input logic [31:0] user,
	input logic [`MVM_DATA_W-1:0] data);
	int waited;
	waited = 0;
	rx_tvalid = 1'b1;
	rx_tid    = id;
	rx_tuser  = user;
	rx_tdata  = data;
	@(negedge clk);
	while (!rx_tready) begin
		waited++;
		assert (waited < TIMEOUT) else fail_with("Timeout: rx_tready stayed low on a beat.");
		@(negedge clk);
	end
	@(posedge clk);
	#1;
	rx_tvalid = 1'b0;
endtask

task automatic write_weight(input logic [5:0] addr, input logic [3:0] mask,
	input logic [`MVM_DATA_W-1:0] row);
	send_beat(mvm_pkg::ID_WEIGHT, {22'd0, mask, addr}, row);
	for (int l = 0; l < `MVM_LANES; l++) begin
		if (mask[l]) weight_model[l][addr] = row;
	end
endtask

task automatic write_inst(input logic [5:0] addr, input logic [15:0] word);
	send_beat(mvm_pkg::ID_INST, {26'd0, addr}, {112'd0, word});
	inst_model[addr] = word;
endtask

task automatic push_input(input logic [`MVM_DATA_W-1:0] v);
	send_beat(mvm_pkg::ID_INPUT, '0, v);
	input_q.push_back(v);
endtask

task automatic push_reduce(input logic [`MVM_DATA_W-1:0] v);
	send_beat(mvm_pkg::ID_REDUCE, '0, v);
	reduce_q.push_back(v);
endtask

// Word layout is rf_addr, accum_addr, last, accum, reduce, en from the top.
task automatic send_exec(input logic [5:0] addr);
	logic [15:0]            inst;
	logic [5:0]             rf;
	logic [5:0]             aa;
	logic                   take_red;
	logic [`MVM_DATA_W-1:0] red;
	logic [`MVM_DATA_W-1:0] res;
	send_beat(mvm_pkg::ID_EXEC, {26'd0, addr}, '0);
	inst     = inst_model[addr];
	rf       = inst[15:10];
	aa       = inst[9:4];
	take_red = inst[1] && (reduce_q.size() != 0);
	red      = take_red ? reduce_q[0] : '0;
	if (inst[0]) begin
		for (int l = 0; l < `MVM_LANES; l++) begin
			res[l*32 +: 32] = lane_dot(input_q[0], weight_model[l][rf]) +
				(inst[2] ? accum_model[aa][l*32 +: 32] : 32'd0) + red[l*32 +: 32];
		end
		accum_model[aa] = res;
		accum_known[aa] = 1'b1;
		expect_q.push_back(res);
		if (inst[3]) void'(input_q.pop_front());
		if (take_red) void'(reduce_q.pop_front());
	end
endtask

task automatic wait_drain();
	int waited;
	waited = 0;
	while (expect_q.size() != 0) begin
		@(posedge clk);
		waited++;
		assert (waited < TIMEOUT) else fail_with("Timeout: results stopped arriving.");
	end
	#1;
endtask

// Output ready mode is sampled at the edge and driven just after it.
initial begin
	tx_tready = 1'b1;
	forever begin
		@(posedge clk);
		hold_now   = hold_tx;
		random_now = random_tx;
		#1;
		ready_seed = lcg_next(ready_seed);
		if (hold_now) tx_tready = 1'b0;
		else if (random_now) tx_tready = (ready_seed[22:21] != 2'b00);
		else tx_tready = 1'b1;
	end
end

// A transfer seen here completes at the next rising edge.
always @(negedge clk) begin
	if (!rst && tx_tvalid && tx_tready) begin
		assert (expect_q.size() != 0) else
			fail_with("An output beat came with no result expected.");
		if (expect_q.size() != 0) begin
			want = expect_q.pop_front();
			assert (tx_tdata === want) else fail_with($sformatf(
				"MISMATCH at %0t: result %h, expected %h", $time, tx_tdata, want));
		end
	end
end

initial begin
	int          n;
	int          pops;
	int          takers;
	int          nred;
	int          waited;
	logic [31:0] r;
	logic [5:0]  base;
	logic [5:0]  aa;
	seed       = 32'hbb1a;
	ready_seed = 32'hbb1a;
	hold_tx    = 1'b0;
	random_tx  = 1'b0;
	rst        = 1'b1;
	rx_tvalid  = 1'b0;
	rx_tdata   = '0;
	rx_tid     = '0;
	rx_tuser   = '0;
	repeat (2) @(posedge clk);
	#1 rst = 1'b0;
	@(negedge clk);
	assert (!tx_tvalid && rx_tready) else
		fail_with("After reset tx_tvalid was high or rx_tready low.");
	@(posedge clk);
	#1;
	for (int a = 0; a < `MVM_MEM_DEPTH; a++) begin
		for (int l = 0; l < `MVM_LANES; l++) begin
			write_weight(6'(a), 4'(1 << l), rand128());
		end
	end
	for (int round = 0; round < 24; round++) begin
		random_tx = 1'b0;
		n         = 1 + int'(rand32() % 12);
		base      = 6'(rand32() >> 26);
		pops      = 0;
		takers    = 0;
		for (int k = 0; k < n; k++) begin
			r  = rand32();
			aa = base + 6'(k);                  // Distinct within a burst.
			write_inst(6'(k), {r[15:10], aa, r[28], r[27] & accum_known[aa], r[26],
				r[31:29] != 3'd0});
			if (r[31:29] != 3'd0 && r[28]) pops++;
			if (r[31:29] != 3'd0 && r[26]) takers++;
		end
		while (input_q.size() < pops + 1) push_input(rand128());
		nred = int'(rand32() % (takers + 2));
		while (nred > 0 && reduce_q.size() < 15) begin
			push_reduce(rand128());
			nred--;
		end
		repeat (3) write_weight(6'(rand32() >> 26), 4'(rand32() >> 28), rand128());
		random_tx = 1'b1;
		for (int k = 0; k < n; k++) send_exec(6'(k));
		wait_drain();
	end
	random_tx = 1'b0;
	if (input_q.size() == 0) push_input(rand128());
	// Accumulate chain on one address.
	write_inst(6'd62, {6'd5, 6'd40, 4'b0001});
	write_inst(6'd63, {6'd5, 6'd40, 4'b0101});
	send_exec(6'd62);
	wait_drain();
	repeat (4) begin
		send_exec(6'd63);
		wait_drain();
	end
	// Reduce until the queue runs dry, then a disabled instruction.
	write_inst(6'd60, {6'd3, 6'd42, 4'b0011});
	write_inst(6'd59, {6'd3, 6'd43, 4'b0010});
	repeat (reduce_q.size() + 1) begin
		send_exec(6'd60);
		wait_drain();
	end
	send_exec(6'd59);
	repeat (`MVM_LANE_LATENCY + 4) @(posedge clk);  // Any beat here has no result expected.
	#1;
	// Output held so results pile up to the limit.
	write_inst(6'd61, {6'd9, 6'd41, 4'b0001});
	hold_tx = 1'b1;
	repeat (9) send_exec(6'd61);
	// Nine queued results still leave room for a new beat.
	repeat (`MVM_LANE_LATENCY + 4) @(negedge clk);
	assert (rx_tready) else
		fail_with("rx_tready dropped before the output queue reached its limit.");
	@(posedge clk);
	#1;
	send_exec(6'd61);
	waited = 0;
	@(negedge clk);
	while (rx_tready) begin
		waited++;
		assert (waited < 50) else
			fail_with("rx_tready stayed high with the output queue at its limit.");
		@(negedge clk);
	end
	repeat (4) begin
		@(negedge clk);
		assert (!rx_tready && tx_tvalid) else
			fail_with("rx_tready rose with the output queue at its limit.");
	end
	@(posedge clk);
	#1;
	hold_tx = 1'b0;
	wait_drain();
	repeat (20) @(posedge clk);
	$display("Verification passed");
	$finish;
end

endmodule

// ==== rtl/mvm_top.sv ====
/* Matrix-vector multiply engine */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    rx_tvalid,
	input  logic [`MVM_DATA_W-1:0]  rx_tdata,
	input  logic [`MVM_TID_W-1:0]   rx_tid,
	input  logic [`MVM_TUSER_W-1:0] rx_tuser,
	output logic                    rx_tready,
	output logic                    tx_tvalid,
	output logic [`MVM_DATA_W-1:0]  tx_tdata,
	input  logic                    tx_tready
);

logic                   inst_wen;
logic [`MVM_LANES-1:0]  weight_wen;
logic [`MVM_ADDR_W-1:0] waddr;
logic                   input_push, reduce_push;
logic                   exec;
logic [`MVM_ADDR_W-1:0] exec_addr;
logic [`MVM_DATA_W-1:0] in_head, red_head;
logic                   in_full, red_full, red_empty;
logic                   in_pop, red_pop;
logic                   out_empty;
logic [`MVM_FIFO_AW:0]  out_count;
logic [`MVM_DATA_W-1:0] accum_rdata;
logic [`MVM_DATA_W-1:0] results;
logic [`MVM_LANES-1:0]  lane_valid;

mvm_issue_if issue ();

mvm_ingress u_ingress (
	.clk, .rst, .rx_tvalid, .rx_tid, .rx_tuser, .in_full, .red_full, .out_count,
	.rx_tready, .inst_wen, .weight_wen, .waddr, .input_push, .reduce_push,
	.exec, .exec_addr
);

mvm_fifo #(.DATA_W(`MVM_DATA_W), .ADDR_W(`MVM_FIFO_AW)) u_input_fifo (
	.clk, .rst, .push(input_push), .idata(rx_tdata), .pop(in_pop),
	.odata(in_head), .empty(), .full(in_full), .count()
);

mvm_fifo #(.DATA_W(`MVM_DATA_W), .ADDR_W(`MVM_FIFO_AW)) u_reduce_fifo (
	.clk, .rst, .push(reduce_push), .idata(rx_tdata), .pop(red_pop),
	.odata(red_head), .empty(red_empty), .full(red_full), .count()
);

// Lanes run in lockstep, lane 0 strobes the whole result.
mvm_fifo #(.DATA_W(`MVM_DATA_W), .ADDR_W(`MVM_FIFO_AW)) u_output_fifo (
	.clk, .rst, .push(lane_valid[0]), .idata(results), .pop(tx_tvalid && tx_tready),
	.odata(tx_tdata), .empty(out_empty), .full(), .count(out_count)
);

assign tx_tvalid = !out_empty;

mvm_sequencer u_sequencer (
	.clk, .rst, .inst_wen, .waddr, .wdata(rx_tdata[$bits(mvm_pkg::inst_t)-1:0]),
	.exec, .exec_addr, .in_head, .red_head, .red_empty, .in_pop, .red_pop,
	.issue(issue)
);

mvm_accum u_accum (
	.clk, .rst, .issue(issue), .result(results), .result_valid(lane_valid[0]),
	.accum_rdata
);

for (genvar g = 0; g < `MVM_LANES; g++) begin : g_lane
	mvm_lane #(.LANE(g)) u_lane (
		.clk          (clk),
		.rst          (rst),
		.weight_wen   (weight_wen[g]),
		.waddr        (waddr),
		.wdata        (rx_tdata),
		.issue        (issue),
		.accum_word   (accum_rdata[g*`MVM_ACC_W +: `MVM_ACC_W]),
		.result       (results[g*`MVM_ACC_W +: `MVM_ACC_W]),
		.result_valid (lane_valid[g])
	);
end

endmodule

// ==== rtl/mvm_lane.sv ====
/* Dot product lane */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_lane #(
	parameter int LANE = 0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   weight_wen,
	input  logic [`MVM_ADDR_W-1:0] waddr,
	input  logic [`MVM_DATA_W-1:0] wdata,
	mvm_issue_if.sink              issue,
	input  logic [`MVM_ACC_W-1:0]  accum_word,
	output logic [`MVM_ACC_W-1:0]  result,
	output logic                   result_valid
);

logic [`MVM_DATA_W-1:0] weight_row;
logic [`MVM_DATA_W-1:0] vec_s1;
logic [`MVM_ACC_W-1:0]  prod_s2 [`MVM_ELEMS];
logic [`MVM_ACC_W-1:0]  tree_sum;
logic [`MVM_ACC_W-1:0]  sum_s3;
logic [`MVM_ACC_W-1:0]  red_s1, red_s2, red_s3;
logic [`MVM_ACC_W-1:0]  acc_s2, acc_s3;
logic                   accum_s1, accum_s2, accum_s3;
logic                   reduce_s1, reduce_s2, reduce_s3;
logic                   valid_s1, valid_s2, valid_s3;

mvm_ram #(
	.DATA_W(`MVM_DATA_W),
	.ADDR_W(`MVM_ADDR_W)
) u_weight_mem (
	.clk   (clk),
	.wen   (weight_wen),
	.waddr (waddr),
	.wdata (wdata),
	.raddr (issue.rf_addr),
	.rdata (weight_row)
);

always_ff @(posedge clk) begin
	if (rst) begin
		valid_s1     <= 1'b0;
		valid_s2     <= 1'b0;
		valid_s3     <= 1'b0;
		result_valid <= 1'b0;
	end else begin
		valid_s1     <= issue.valid;
		valid_s2     <= valid_s1;
		valid_s3     <= valid_s2;
		result_valid <= valid_s3;
	end
end

always_comb begin
	tree_sum = '0;
	for (int i = 0; i < `MVM_ELEMS; i++) begin
		tree_sum = tree_sum + prod_s2[i];
	end
end

always_ff @(posedge clk) begin
	// Stage 1, weight row read alongside the operands.
	vec_s1    <= issue.vector;
	red_s1    <= issue.reduce_data[LANE*`MVM_ACC_W +: `MVM_ACC_W];
	accum_s1  <= issue.accum;
	reduce_s1 <= issue.reduce;
	// Stage 2, element products.
	for (int i = 0; i < `MVM_ELEMS; i++) begin
		prod_s2[i] <= vec_s1[i*`MVM_ELEM_W +: `MVM_ELEM_W] *
			weight_row[i*`MVM_ELEM_W +: `MVM_ELEM_W];
	end
	acc_s2    <= accum_word;  // Accumulator read is valid in this cycle only.
	red_s2    <= red_s1;
	accum_s2  <= accum_s1;
	reduce_s2 <= reduce_s1;
	// Stage 3, product sum.
	sum_s3    <= tree_sum;
	acc_s3    <= acc_s2;
	red_s3    <= red_s2;
	accum_s3  <= accum_s2;
	reduce_s3 <= reduce_s2;
	// Stage 4, wraps at the result width.
	result    <= sum_s3 + (accum_s3 ? acc_s3 : '0) + (reduce_s3 ? red_s3 : '0);
end

endmodule

// ==== rtl/mvm_accum.sv ====
/* Accumulator memory */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_accum (
	input  logic                   clk,
	input  logic                   rst,
	mvm_issue_if.sink              issue,
	input  logic [`MVM_DATA_W-1:0] result,
	input  logic                   result_valid,
	output logic [`MVM_DATA_W-1:0] accum_rdata
);

logic [`MVM_ADDR_W-1:0] addr_pipe [`MVM_LANE_LATENCY];

// Address follows the lanes so the write lands with the result.
always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `MVM_LANE_LATENCY; i++) begin
			addr_pipe[i] <= '0;
		end
	end else begin
		addr_pipe[0] <= issue.accum_addr;
		for (int i = 1; i < `MVM_LANE_LATENCY; i++) begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
	end
end

// Read at the issue edge, word is held by the lanes.
mvm_ram #(
	.DATA_W(`MVM_DATA_W),
	.ADDR_W(`MVM_ADDR_W)
) u_accum_mem (
	.clk   (clk),
	.wen   (result_valid),
	.waddr (addr_pipe[`MVM_LANE_LATENCY-1]),
	.wdata (result),
	.raddr (issue.accum_addr),
	.rdata (accum_rdata)
);

endmodule

// ==== rtl/mvm_sequencer.sv ====
/* Instruction sequencer */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     inst_wen,
	input  logic [`MVM_ADDR_W-1:0]   waddr,
	input  mvm_pkg::inst_t           wdata,
	input  logic                     exec,
	input  logic [`MVM_ADDR_W-1:0]   exec_addr,
	input  logic [`MVM_DATA_W-1:0]   in_head,
	input  logic [`MVM_DATA_W-1:0]   red_head,
	input  logic                     red_empty,
	output logic                     in_pop,
	output logic                     red_pop,
	mvm_issue_if.seq                 issue
);

logic [$bits(mvm_pkg::inst_t)-1:0] inst_rdata;
mvm_pkg::inst_t                    inst;
logic                              exec_d;
logic                              fire;
logic                              take_red;

mvm_ram #(
	.DATA_W($bits(mvm_pkg::inst_t)),
	.ADDR_W(`MVM_ADDR_W)
) u_inst_mem (
	.clk   (clk),
	.wen   (inst_wen),
	.waddr (waddr),
	.wdata (wdata),
	.raddr (exec_addr),
	.rdata (inst_rdata)
);

// Exec strobe lines up with the registered memory read.
always_ff @(posedge clk) begin
	if (rst) begin
		exec_d <= 1'b0;
	end else begin
		exec_d <= exec;
	end
end

assign inst     = mvm_pkg::inst_t'(inst_rdata);
assign fire     = exec_d && inst.en;
assign take_red = inst.reduce && !red_empty;

assign issue.valid       = fire;
assign issue.rf_addr     = inst.rf_addr;
assign issue.accum_addr  = inst.accum_addr;
assign issue.accum       = inst.accum;
assign issue.reduce      = inst.reduce;
assign issue.vector      = in_head;
assign issue.reduce_data = take_red ? red_head : '0;  // Empty queue adds zero.

// Input vector stays at the head until a last instruction.
assign in_pop  = fire && inst.last;
assign red_pop = fire && take_red;

endmodule

// ==== rtl/mvm_ingress.sv ====
/* Stream beat decoder */

`timescale 1ns/100ps

`include "mvm_params.svh"

module mvm_ingress (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     rx_tvalid,
	input  logic [`MVM_TID_W-1:0]    rx_tid,
	input  logic [`MVM_TUSER_W-1:0]  rx_tuser,
	input  logic                     in_full,
	input  logic                     red_full,
	input  logic [`MVM_FIFO_AW:0]    out_count,
	output logic                     rx_tready,
	output logic                     inst_wen,
	output logic [`MVM_LANES-1:0]    weight_wen,
	output logic [`MVM_ADDR_W-1:0]   waddr,
	output logic                     input_push,
	output logic                     reduce_push,
	output logic                     exec,
	output logic [`MVM_ADDR_W-1:0]   exec_addr
);

logic               accept;
logic               exec_hit;
mvm_pkg::stream_id_e id;

// Output queue keeps room for every result still in the lanes.
assign rx_tready = !in_full && !red_full &&
	(out_count < (`MVM_FIFO_DEPTH - `MVM_LANE_LATENCY - 2));

assign accept = rx_tvalid && rx_tready;
assign id     = mvm_pkg::stream_id_e'(rx_tid);
assign waddr  = rx_tuser[`MVM_ADDR_W-1:0];

always_comb begin
	inst_wen    = 1'b0;
	weight_wen  = '0;
	input_push  = 1'b0;
	reduce_push = 1'b0;
	exec_hit    = 1'b0;
	if (accept) begin
		case (id)
			mvm_pkg::ID_INST:   inst_wen    = 1'b1;
			mvm_pkg::ID_REDUCE: reduce_push = 1'b1;
			mvm_pkg::ID_INPUT:  input_push  = 1'b1;
			mvm_pkg::ID_WEIGHT: weight_wen  = rx_tuser[`MVM_ADDR_W +: `MVM_LANES];
			mvm_pkg::ID_EXEC:   exec_hit    = 1'b1;
			default:            ;                      // Unknown ids are dropped.
		endcase
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		exec <= 1'b0;
	end else begin
		exec <= exec_hit;
	end
end

always_ff @(posedge clk) begin
	if (exec_hit) begin
		exec_addr <= waddr;
	end
end

endmodule

// ==== rtl/mvm_fifo.sv ====
/* Show-ahead queue */

`timescale 1ns/100ps

module mvm_fifo #(
	parameter int DATA_W = 128,
	parameter int ADDR_W = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  logic [DATA_W-1:0] idata,
	input  logic              pop,
	output logic [DATA_W-1:0] odata,
	output logic              empty,
	output logic              full,
	output logic [ADDR_W:0]   count
);

logic [DATA_W-1:0] mem [1 << ADDR_W];
logic [ADDR_W-1:0] head;
logic [ADDR_W-1:0] tail;
logic              do_push;
logic              do_pop;

assign do_push = push && !full;   // Push on full is dropped.
assign do_pop  = pop && !empty;

always_ff @(posedge clk) begin
	if (do_push) begin
		mem[tail] <= idata;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		head  <= '0;
		tail  <= '0;
		count <= '0;
	end else begin
		if (do_push) begin
			tail <= tail + 1'b1;
		end
		if (do_pop) begin
			head <= head + 1'b1;
		end
		if (do_push && !do_pop) begin
			count <= count + 1'b1;
		end else if (!do_push && do_pop) begin
			count <= count - 1'b1;
		end
	end
end

assign odata = mem[head];  // Head visible before the pop.
assign empty = (count == '0);
assign full  = (count == (ADDR_W + 1)'(1 << ADDR_W));

endmodule

// ==== rtl/mvm_ram.sv ====
/* Simple dual-port memory */

`timescale 1ns/100ps

module mvm_ram #(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 6
) (
	input  logic              clk,
	input  logic              wen,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [DATA_W-1:0] wdata,
	input  logic [ADDR_W-1:0] raddr,
	output logic [DATA_W-1:0] rdata
);

logic [DATA_W-1:0] mem [1 << ADDR_W];

// Read returns the old word on a same-address write.
always_ff @(posedge clk) begin
	if (wen) begin
		mem[waddr] <= wdata;
	end
	rdata <= mem[raddr];
end

endmodule

// ==== rtl/mvm_issue_if.sv ====
/* Instruction issue bundle */

`timescale 1ns/100ps

`include "mvm_params.svh"

interface mvm_issue_if;

logic                   valid;        // One cycle per issued instruction.
logic [`MVM_ADDR_W-1:0] rf_addr;
logic [`MVM_ADDR_W-1:0] accum_addr;
logic                   accum;
logic                   reduce;
logic [`MVM_DATA_W-1:0] vector;       // Input queue head.
logic [`MVM_DATA_W-1:0] reduce_data;  // Zero unless a reduction word is taken.

modport seq (
	output valid, rf_addr, accum_addr, accum, reduce, vector, reduce_data
);

modport sink (
	input valid, rf_addr, accum_addr, accum, reduce, vector, reduce_data
);

endinterface

// ==== rtl/mvm_pkg.sv ====
/* MVM engine types */

`include "mvm_params.svh"

package mvm_pkg;

// Stream id carried on rx_tid.
typedef enum logic [`MVM_TID_W-1:0] {
	ID_INST   = 8'd0,
	ID_REDUCE = 8'd1,
	ID_INPUT  = 8'd2,
	ID_WEIGHT = 8'd3,
	ID_EXEC   = 8'd4
} stream_id_e;

// Instruction word, held in the low bits of a data beat.
typedef struct packed {
	logic [`MVM_ADDR_W-1:0] rf_addr;
	logic [`MVM_ADDR_W-1:0] accum_addr;
	logic                   last;    // Pops the input queue.
	logic                   accum;   // Adds the old accumulator word.
	logic                   reduce;  // Adds the reduction head.
	logic                   en;
} inst_t;

endpackage

// ==== rtl/mvm_params.svh ====
/* MVM engine sizes and latencies */

`ifndef MVM_PARAMS_SVH
`define MVM_PARAMS_SVH

`define MVM_LANES         4
`define MVM_ELEMS         8
`define MVM_ELEM_W        16
`define MVM_ACC_W         32
`define MVM_DATA_W        128  // Elements times element width, lanes times result width.

`define MVM_ADDR_W        6    // Instruction, weight and accumulator memories.
`define MVM_MEM_DEPTH     64

`define MVM_FIFO_AW       4
`define MVM_FIFO_DEPTH    16

`define MVM_LANE_LATENCY  4    // Cycles from issue to lane result.

`define MVM_TUSER_W       32
`define MVM_TID_W         8

`endif
